// File: source/rv_pkg.sv
package rv_pkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int WORD_ADDR_W = XLEN - 2;  // word addressed memory ports

    // major opcodes
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    // funct3 of the alu group
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SHR     = 3'b101;  // srl or sra by bit 30
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [XLEN-1:0] NOP_INSN = 32'h0000_0013;  // addi x0, x0, 0

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    // per instruction control, all zero is a bubble
    typedef struct packed {
        logic    reg_write;
        logic    mem_to_reg;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src_imm;
        logic    link_pc;     // result is pc+4
        logic    is_branch;
        logic    branch_ne;   // bne when set, else beq
        logic    is_jalr;
        logic    is_jal;
        alu_op_e alu_op;
    } ctrl_t;

endpackage

// File: source/fwd_if.sv
`timescale 1ns/10ps

interface fwd_if import rv_pkg::*; ();

    // EX/MEM entry
    logic [REG_ADDR_W-1:0] ex_mem_rd;
    logic                  ex_mem_reg_write;
    logic                  ex_mem_mem_read;
    logic [XLEN-1:0]       ex_mem_value;

    // writeback result
    logic [REG_ADDR_W-1:0] wb_rd;
    logic                  wb_reg_write;
    logic [XLEN-1:0]       wb_value;

    modport source (
        output ex_mem_rd, ex_mem_reg_write, ex_mem_mem_read, ex_mem_value,
        output wb_rd, wb_reg_write, wb_value
    );

    modport forward (
        input ex_mem_rd, ex_mem_reg_write, ex_mem_mem_read, ex_mem_value,
        input wb_rd, wb_reg_write, wb_value
    );

    modport writeback (
        input wb_rd, wb_reg_write, wb_value
    );

endinterface

// File: source/register_file.sv
`timescale 1ns/10ps

module register_file import rv_pkg::*; #(
    parameter int NUM_REGS = 32
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  i_we,
    input  logic [REG_ADDR_W-1:0] i_waddr,
    input  logic [XLEN-1:0]       i_wdata,
    input  logic [REG_ADDR_W-1:0] i_raddr1,
    input  logic [REG_ADDR_W-1:0] i_raddr2,
    output logic [XLEN-1:0]       o_rdata1,
    output logic [XLEN-1:0]       o_rdata2
);

    logic [XLEN-1:0] regs [NUM_REGS];

    assign o_rdata1 = regs[i_raddr1];
    assign o_rdata2 = regs[i_raddr2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_waddr != '0) begin  // x0 stays zero
            regs[i_waddr] <= i_wdata;
        end
    end

endmodule

// File: source/fetch_stage.sv
`timescale 1ns/10ps

module fetch_stage import rv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   i_stall,
    input  logic                   i_redirect,
    input  logic [XLEN-1:0]        i_redirect_pc,
    input  logic [XLEN-1:0]        i_imem_rdata,
    output logic [WORD_ADDR_W-1:0] o_imem_addr,
    output logic [XLEN-1:0]        o_pc_cur,
    output logic [XLEN-1:0]        o_pc,
    output logic [XLEN-1:0]        o_insn
);

    logic [XLEN-1:0] pc;

    assign o_imem_addr = pc[XLEN-1:2];  // same cycle fetch
    assign o_pc_cur    = pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (i_redirect) begin  // redirect wins over a stall
            pc <= i_redirect_pc;
        end else if (!i_stall) begin
            pc <= pc + 32'd4;
        end
    end

    // IF/ID register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_pc   <= '0;
            o_insn <= NOP_INSN;
        end else if (i_redirect) begin
            o_pc   <= pc;
            o_insn <= NOP_INSN;  // squash the wrong path word
        end else if (!i_stall) begin
            o_pc   <= pc;
            o_insn <= i_imem_rdata;
        end
    end

endmodule

// File: source/decode_stage.sv
`timescale 1ns/10ps

module decode_stage import rv_pkg::*; #(
    parameter int NUM_REGS = 32
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [XLEN-1:0]        i_pc,
    input  logic [XLEN-1:0]        i_insn,
    input  logic                   i_flush,
    fwd_if.writeback               wb,
    output logic                   o_stall,
    output ctrl_t                  o_ctrl,
    output logic [XLEN-1:0]        o_pc,
    output logic [XLEN-1:0]        o_rs1_val,
    output logic [XLEN-1:0]        o_rs2_val,
    output logic [REG_ADDR_W-1:0]  o_rs1,
    output logic [REG_ADDR_W-1:0]  o_rs2,
    output logic [REG_ADDR_W-1:0]  o_rd,
    output logic [XLEN-1:0]        o_imm
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm_i;
    logic [XLEN-1:0]       imm_s;
    logic [XLEN-1:0]       imm_b;
    logic [XLEN-1:0]       imm_j;
    logic [XLEN-1:0]       imm;
    ctrl_t                 ctrl;
    logic [XLEN-1:0]       rf_rdata1;
    logic [XLEN-1:0]       rf_rdata2;
    logic [XLEN-1:0]       rs1_val;
    logic [XLEN-1:0]       rs2_val;

    assign opcode = i_insn[6:0];
    assign funct3 = i_insn[14:12];
    assign rd     = i_insn[11:7];
    assign rs1    = i_insn[19:15];
    assign rs2    = i_insn[24:20];

    assign imm_i = {{20{i_insn[31]}}, i_insn[31:20]};
    assign imm_s = {{20{i_insn[31]}}, i_insn[31:25], i_insn[11:7]};
    assign imm_b = {{19{i_insn[31]}}, i_insn[31], i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};
    assign imm_j = {{11{i_insn[31]}}, i_insn[31], i_insn[19:12], i_insn[20], i_insn[30:21], 1'b0};

    always_comb begin
        ctrl = '0;
        imm  = imm_i;
        case (opcode)
            OP_R: ctrl.reg_write = 1'b1;
            OP_IMM: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OP_LOAD: begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OP_STORE: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                imm              = imm_s;
            end
            OP_BRANCH: begin
                ctrl.is_branch = 1'b1;
                ctrl.branch_ne = funct3[0];
                imm            = imm_b;
            end
            OP_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.link_pc   = 1'b1;
                ctrl.is_jal    = 1'b1;
                imm            = imm_j;
            end
            OP_JALR: begin
                ctrl.reg_write = 1'b1;
                ctrl.link_pc   = 1'b1;
                ctrl.is_jalr   = 1'b1;
            end
            default: ;  // unsupported opcode decodes as a nop
        endcase

        if (opcode == OP_R || opcode == OP_IMM) begin
            case (funct3)
                F3_ADD_SUB: ctrl.alu_op = (i_insn[30] && opcode[5]) ? ALU_SUB : ALU_ADD;
                F3_SLL:     ctrl.alu_op = ALU_SLL;
                F3_SLT:     ctrl.alu_op = ALU_SLT;
                F3_XOR:     ctrl.alu_op = ALU_XOR;
                F3_SHR:     ctrl.alu_op = i_insn[30] ? ALU_SRA : ALU_SRL;
                F3_OR:      ctrl.alu_op = ALU_OR;
                F3_AND:     ctrl.alu_op = ALU_AND;
                default:    ctrl.alu_op = ALU_ADD;
            endcase
        end
    end

    register_file #(
        .NUM_REGS (NUM_REGS)
    ) register_file_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_we     (wb.wb_reg_write),
        .i_waddr  (wb.wb_rd),
        .i_wdata  (wb.wb_value),
        .i_raddr1 (rs1),
        .i_raddr2 (rs2),
        .o_rdata1 (rf_rdata1),
        .o_rdata2 (rf_rdata2)
    );

    // writeback in the same cycle bypasses the array
    assign rs1_val = (wb.wb_reg_write && wb.wb_rd != '0 && wb.wb_rd == rs1) ? wb.wb_value
                                                                            : rf_rdata1;
    assign rs2_val = (wb.wb_reg_write && wb.wb_rd != '0 && wb.wb_rd == rs2) ? wb.wb_value
                                                                            : rf_rdata2;

    // load in EX whose result the next instruction needs
    assign o_stall = o_ctrl.mem_read && (o_rd != '0) && (o_rd == rs1 || o_rd == rs2);

    // ID/EX register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_ctrl    <= '0;
            o_pc      <= '0;
            o_rs1_val <= '0;
            o_rs2_val <= '0;
            o_rs1     <= '0;
            o_rs2     <= '0;
            o_rd      <= '0;
            o_imm     <= '0;
        end else begin
            o_ctrl    <= (i_flush || o_stall) ? '0 : ctrl;  // bubble
            o_pc      <= i_pc;
            o_rs1_val <= rs1_val;
            o_rs2_val <= rs2_val;
            o_rs1     <= rs1;
            o_rs2     <= rs2;
            o_rd      <= rd;
            o_imm     <= imm;
        end
    end

endmodule

// File: source/execute_stage.sv
`timescale 1ns/10ps

module execute_stage import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  ctrl_t                 i_ctrl,
    input  logic [XLEN-1:0]       i_pc,
    input  logic [XLEN-1:0]       i_rs1_val,
    input  logic [XLEN-1:0]       i_rs2_val,
    input  logic [REG_ADDR_W-1:0] i_rs1,
    input  logic [REG_ADDR_W-1:0] i_rs2,
    input  logic [REG_ADDR_W-1:0] i_rd,
    input  logic [XLEN-1:0]       i_imm,
    fwd_if.forward                fwd,
    output logic                  o_redirect,
    output logic [XLEN-1:0]       o_redirect_pc,
    output ctrl_t                 o_ctrl,
    output logic [REG_ADDR_W-1:0] o_rd,
    output logic [XLEN-1:0]       o_alu_result,
    output logic [XLEN-1:0]       o_store_data
);

    logic [XLEN-1:0] rs1_fwd;
    logic [XLEN-1:0] rs2_fwd;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_out;
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] jalr_target;
    logic            br_taken;

    // newest producer first, a load in EX/MEM has no data yet
    function automatic logic [XLEN-1:0] fwd_sel(input logic [REG_ADDR_W-1:0] rs,
                                                input logic [XLEN-1:0]       reg_val);
        if (rs != '0 && fwd.ex_mem_reg_write && !fwd.ex_mem_mem_read && fwd.ex_mem_rd == rs) begin
            return fwd.ex_mem_value;
        end else if (rs != '0 && fwd.wb_reg_write && fwd.wb_rd == rs) begin
            return fwd.wb_value;
        end
        return reg_val;
    endfunction

    always_comb begin
        rs1_fwd = fwd_sel(i_rs1, i_rs1_val);
        rs2_fwd = fwd_sel(i_rs2, i_rs2_val);
    end

    assign op_b = i_ctrl.alu_src_imm ? i_imm : rs2_fwd;

    always_comb begin
        case (i_ctrl.alu_op)
            ALU_SUB: alu_out = rs1_fwd - op_b;
            ALU_AND: alu_out = rs1_fwd & op_b;
            ALU_OR:  alu_out = rs1_fwd | op_b;
            ALU_XOR: alu_out = rs1_fwd ^ op_b;
            ALU_SLT: alu_out = {{(XLEN-1){1'b0}}, $signed(rs1_fwd) < $signed(op_b)};
            ALU_SLL: alu_out = rs1_fwd << op_b[4:0];
            ALU_SRL: alu_out = rs1_fwd >> op_b[4:0];
            ALU_SRA: alu_out = $signed(rs1_fwd) >>> op_b[4:0];
            default: alu_out = rs1_fwd + op_b;
        endcase
    end

    assign result = i_ctrl.link_pc ? i_pc + 32'd4 : alu_out;  // link address for jal/jalr

    // branch and jump resolution, a bubble has all flags low
    assign br_taken      = i_ctrl.is_branch && ((rs1_fwd == rs2_fwd) != i_ctrl.branch_ne);
    assign o_redirect    = br_taken || i_ctrl.is_jal || i_ctrl.is_jalr;
    assign jalr_target   = rs1_fwd + i_imm;
    assign o_redirect_pc = i_ctrl.is_jalr ? {jalr_target[XLEN-1:1], 1'b0} : i_pc + i_imm;

    // EX/MEM register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_ctrl       <= '0;
            o_rd         <= '0;
            o_alu_result <= '0;
            o_store_data <= '0;
        end else begin
            o_ctrl       <= i_ctrl;
            o_rd         <= i_rd;
            o_alu_result <= result;
            o_store_data <= rs2_fwd;
        end
    end

endmodule

// File: source/memory_stage.sv
`timescale 1ns/10ps

module memory_stage import rv_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  ctrl_t                  i_ctrl,
    input  logic [REG_ADDR_W-1:0]  i_rd,
    input  logic [XLEN-1:0]        i_alu_result,
    input  logic [XLEN-1:0]        i_store_data,
    input  logic [XLEN-1:0]        i_dmem_rdata,
    fwd_if.source                  fwd,
    output logic                   o_dmem_ren,
    output logic                   o_dmem_wen,
    output logic [WORD_ADDR_W-1:0] o_dmem_addr,
    output logic [XLEN-1:0]        o_dmem_wdata
);

    // MEM/WB entry
    logic                  wb_reg_write;
    logic                  wb_mem_to_reg;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_alu;
    logic [XLEN-1:0]       wb_load;

    // data port straight from EX/MEM
    assign o_dmem_ren   = i_ctrl.mem_read;
    assign o_dmem_wen   = i_ctrl.mem_write;
    assign o_dmem_addr  = i_alu_result[XLEN-1:2];
    assign o_dmem_wdata = i_store_data;

    assign fwd.ex_mem_rd        = i_rd;
    assign fwd.ex_mem_reg_write = i_ctrl.reg_write;
    assign fwd.ex_mem_mem_read  = i_ctrl.mem_read;
    assign fwd.ex_mem_value     = i_alu_result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_reg_write  <= 1'b0;
            wb_mem_to_reg <= 1'b0;
            wb_rd         <= '0;
            wb_alu        <= '0;
            wb_load       <= '0;
        end else begin
            wb_reg_write  <= i_ctrl.reg_write;
            wb_mem_to_reg <= i_ctrl.mem_to_reg;
            wb_rd         <= i_rd;
            wb_alu        <= i_alu_result;
            wb_load       <= i_dmem_rdata;
        end
    end

    // writeback select
    assign fwd.wb_rd        = wb_rd;
    assign fwd.wb_reg_write = wb_reg_write;
    assign fwd.wb_value     = wb_mem_to_reg ? wb_load : wb_alu;

endmodule

// File: source/riscv_pipeline.sv
`timescale 1ns/10ps

module riscv_pipeline import rv_pkg::*; #(
    parameter int              NUM_REGS = 32,
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [XLEN-1:0]        i_imem_rdata,
    input  logic [XLEN-1:0]        i_dmem_rdata,
    output logic [WORD_ADDR_W-1:0] o_imem_addr,
    output logic                   o_dmem_ren,
    output logic                   o_dmem_wen,
    output logic [WORD_ADDR_W-1:0] o_dmem_addr,
    output logic [XLEN-1:0]        o_dmem_wdata,
    output logic [XLEN-1:0]        o_pc
);

    // hazard control
    logic            stall;
    logic            redirect;
    logic [XLEN-1:0] redirect_pc;

    // IF/ID
    logic [XLEN-1:0] if_pc;
    logic [XLEN-1:0] if_insn;

    // ID/EX
    ctrl_t                 id_ctrl;
    logic [XLEN-1:0]       id_pc;
    logic [XLEN-1:0]       id_rs1_val;
    logic [XLEN-1:0]       id_rs2_val;
    logic [REG_ADDR_W-1:0] id_rs1;
    logic [REG_ADDR_W-1:0] id_rs2;
    logic [REG_ADDR_W-1:0] id_rd;
    logic [XLEN-1:0]       id_imm;

    // EX/MEM
    ctrl_t                 ex_ctrl;
    logic [REG_ADDR_W-1:0] ex_rd;
    logic [XLEN-1:0]       ex_alu_result;
    logic [XLEN-1:0]       ex_store_data;

    fwd_if fwd_i ();

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) fetch_stage_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_stall       (stall),
        .i_redirect    (redirect),
        .i_redirect_pc (redirect_pc),
        .i_imem_rdata  (i_imem_rdata),
        .o_imem_addr   (o_imem_addr),
        .o_pc_cur      (o_pc),
        .o_pc          (if_pc),
        .o_insn        (if_insn)
    );

    decode_stage #(
        .NUM_REGS (NUM_REGS)
    ) decode_stage_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_pc      (if_pc),
        .i_insn    (if_insn),
        .i_flush   (redirect),
        .wb        (fwd_i.writeback),
        .o_stall   (stall),
        .o_ctrl    (id_ctrl),
        .o_pc      (id_pc),
        .o_rs1_val (id_rs1_val),
        .o_rs2_val (id_rs2_val),
        .o_rs1     (id_rs1),
        .o_rs2     (id_rs2),
        .o_rd      (id_rd),
        .o_imm     (id_imm)
    );

    execute_stage execute_stage_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_ctrl        (id_ctrl),
        .i_pc          (id_pc),
        .i_rs1_val     (id_rs1_val),
        .i_rs2_val     (id_rs2_val),
        .i_rs1         (id_rs1),
        .i_rs2         (id_rs2),
        .i_rd          (id_rd),
        .i_imm         (id_imm),
        .fwd           (fwd_i.forward),
        .o_redirect    (redirect),
        .o_redirect_pc (redirect_pc),
        .o_ctrl        (ex_ctrl),
        .o_rd          (ex_rd),
        .o_alu_result  (ex_alu_result),
        .o_store_data  (ex_store_data)
    );

    memory_stage memory_stage_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_ctrl       (ex_ctrl),
        .i_rd         (ex_rd),
        .i_alu_result (ex_alu_result),
        .i_store_data (ex_store_data),
        .i_dmem_rdata (i_dmem_rdata),
        .fwd          (fwd_i.source),
        .o_dmem_ren   (o_dmem_ren),
        .o_dmem_wen   (o_dmem_wen),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_wdata (o_dmem_wdata)
    );

endmodule

// File: tests/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// each program ends in jal x0,0 and lists the stores it must make in order
task automatic build_program_table();
    for (int p = 0; p < NUM_PROGS; p++) begin
        prog_len[p]  = 0;
        exp_count[p] = 0;
        budget[p]    = RUN_BUDGET;
    end

    // dependent alu chain forwarding from EX/MEM and writeback
    prog_name[0] = "alu_chain";
    emit(0, imm_op(F3_ADD, 1'b0, 1, 0, 5));       // x1 = 5
    emit(0, imm_op(F3_ADD, 1'b0, 2, 1, 7));       // x2 = 12
    emit(0, reg_op(F3_ADD, 1'b0, 3, 2, 1));       // x3 = 17
    emit(0, reg_op(F3_ADD, 1'b1, 4, 3, 2));       // sub, x4 = 5
    emit(0, reg_op(F3_AND, 1'b0, 5, 4, 3));       // x5 = 1
    emit(0, reg_op(F3_OR, 1'b0, 6, 5, 3));        // x6 = 17
    emit(0, reg_op(F3_XOR, 1'b0, 7, 6, 2));       // x7 = 29
    emit(0, store_word(7, 0, 32'h50));            // store data from EX/MEM
    emit(0, store_word(3, 0, 32'h40));
    emit(0, store_word(4, 0, 32'h44));
    emit(0, store_word(5, 0, 32'h48));
    emit(0, store_word(6, 0, 32'h4c));
    emit(0, jal_to(0, 0));
    expect_store(0, 32'h50, 32'd29);
    expect_store(0, 32'h40, 32'd17);
    expect_store(0, 32'h44, 32'd5);
    expect_store(0, 32'h48, 32'd1);
    expect_store(0, 32'h4c, 32'd17);

    // compares and shifts with a negative operand
    prog_name[1] = "slt_shift";
    emit(1, imm_op(F3_ADD, 1'b0, 1, 0, -8));      // x1 = -8
    emit(1, imm_op(F3_ADD, 1'b0, 2, 0, 3));       // x2 = 3
    emit(1, reg_op(F3_SLT, 1'b0, 3, 1, 2));       // -8 < 3
    emit(1, reg_op(F3_SLT, 1'b0, 4, 2, 1));       // 3 < -8
    emit(1, reg_op(F3_SLL, 1'b0, 5, 2, 2));       // 3 << 3
    emit(1, reg_op(F3_SR, 1'b0, 6, 1, 2));        // srl
    emit(1, reg_op(F3_SR, 1'b1, 7, 1, 2));        // sra
    emit(1, imm_op(F3_SR, 1'b1, 8, 1, 1));        // srai by 1
    emit(1, store_word(3, 0, 32'h60));
    emit(1, store_word(4, 0, 32'h64));
    emit(1, store_word(5, 0, 32'h68));
    emit(1, store_word(6, 0, 32'h6c));
    emit(1, store_word(7, 0, 32'h70));
    emit(1, store_word(8, 0, 32'h74));
    emit(1, jal_to(0, 0));
    expect_store(1, 32'h60, 32'h0000_0001);
    expect_store(1, 32'h64, 32'h0000_0000);
    expect_store(1, 32'h68, 32'h0000_0018);
    expect_store(1, 32'h6c, 32'h1fff_ffff);
    expect_store(1, 32'h70, 32'hffff_ffff);
    expect_store(1, 32'h74, 32'hffff_fffc);

    // two loads each followed at once by a use
    prog_name[2] = "load_use";
    emit(2, imm_op(F3_ADD, 1'b0, 1, 0, 1000));
    emit(2, imm_op(F3_ADD, 1'b0, 2, 0, 77));
    emit(2, store_word(1, 0, 32'h80));
    emit(2, load_word(3, 0, 32'h80));             // x3 = 1000
    emit(2, reg_op(F3_ADD, 1'b0, 4, 3, 2));       // needs one bubble
    emit(2, store_word(4, 0, 32'h84));
    emit(2, load_word(5, 0, 32'h84));
    emit(2, store_word(5, 0, 32'h88));            // loaded value as store data
    emit(2, jal_to(0, 0));
    expect_store(2, 32'h80, 32'd1000);
    expect_store(2, 32'h84, 32'd1077);
    expect_store(2, 32'h88, 32'd1077);

    // taken and untaken beq and bne
    prog_name[3] = "branches";
    emit(3, imm_op(F3_ADD, 1'b0, 1, 0, 4));
    emit(3, imm_op(F3_ADD, 1'b0, 2, 0, 4));
    emit(3, imm_op(F3_ADD, 1'b0, 3, 0, 9));
    emit(3, branch_to(F3_BEQ, 1, 2, 8));          // taken
    emit(3, store_word(3, 0, 32'ha0));            // skipped
    emit(3, branch_to(F3_BNE, 1, 2, 8));          // not taken
    emit(3, store_word(1, 0, 32'ha4));
    emit(3, branch_to(F3_BNE, 1, 3, 8));          // taken
    emit(3, store_word(3, 0, 32'ha8));            // skipped
    emit(3, branch_to(F3_BEQ, 1, 3, 8));          // not taken
    emit(3, store_word(3, 0, 32'hac));
    emit(3, store_word(2, 0, 32'hb0));
    emit(3, jal_to(0, 0));
    expect_store(3, 32'ha4, 32'd4);
    expect_store(3, 32'hac, 32'd9);
    expect_store(3, 32'hb0, 32'd4);

    // jal and jalr links with the jalr target's bit 0 cleared
    prog_name[4] = "jumps";
    emit(4, jal_to(1, 12));                       // to word 3, x1 = 4
    emit(4, store_word(1, 0, 32'hc0));
    emit(4, store_word(1, 0, 32'hc4));
    emit(4, store_word(1, 0, 32'hc8));
    emit(4, imm_op(F3_ADD, 1'b0, 6, 0, 32));
    emit(4, jalr_to(7, 6, 4));                    // to word 9, x7 = 24
    emit(4, store_word(6, 0, 32'hcc));
    emit(4, store_word(6, 0, 32'hd0));
    emit(4, store_word(6, 0, 32'hd4));
    emit(4, store_word(7, 0, 32'hd8));
    emit(4, jalr_to(8, 0, 49));                   // to word 12, x8 = 44
    emit(4, store_word(8, 0, 32'hdc));
    emit(4, jal_to(9, 4));                        // at pc 48 so x9 = 52
    emit(4, store_word(8, 0, 32'he0));
    emit(4, store_word(9, 0, 32'he4));
    emit(4, jal_to(0, 0));
    expect_store(4, 32'hc8, 32'd4);
    expect_store(4, 32'hd8, 32'd24);
    expect_store(4, 32'he0, 32'd44);
    expect_store(4, 32'he4, 32'd52);

    // x0 ignores writes
    prog_name[5] = "x0_writes";
    emit(5, imm_op(F3_ADD, 1'b0, 0, 0, 55));
    emit(5, store_word(0, 0, 32'he0));
    emit(5, imm_op(F3_ADD, 1'b0, 1, 0, 9));
    emit(5, reg_op(F3_ADD, 1'b0, 0, 1, 1));
    emit(5, reg_op(F3_ADD, 1'b0, 2, 0, 1));       // x2 = 9
    emit(5, store_word(0, 0, 32'he4));
    emit(5, store_word(2, 0, 32'he8));
    emit(5, load_word(0, 0, 32'he8));
    emit(5, store_word(0, 0, 32'hec));
    emit(5, jal_to(0, 0));
    expect_store(5, 32'he0, 32'd0);
    expect_store(5, 32'he4, 32'd0);
    expect_store(5, 32'he8, 32'd9);
    expect_store(5, 32'hec, 32'd0);
endtask

`endif

// File: tests/tb_riscv_pipeline.sv
`timescale 1ns/10ps

module tb_riscv_pipeline;

    localparam int HALF_PERIOD  = 10;  // 20 ns clock
    localparam int RESET_CYCLES = 4;
    localparam int NUM_PROGS    = 6;
    localparam int PROG_WORDS   = 16;
    localparam int MAX_STORES   = 8;
    localparam int IMEM_WORDS   = 16;
    localparam int DMEM_WORDS   = 64;
    localparam int RUN_BUDGET   = 40;  // cycles per program
    localparam int WD_MARGIN    = 50;

    localparam logic [31:0] NOP_WORD = 32'h0000_0013;

    // funct3 codes from the ISA
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SR  = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    logic        clk;
    logic        rst_n;
    logic [31:0] i_imem_rdata;
    logic [31:0] i_dmem_rdata;
    logic [29:0] o_imem_addr;
    logic        o_dmem_ren;
    logic        o_dmem_wen;
    logic [29:0] o_dmem_addr;
    logic [31:0] o_dmem_wdata;
    logic [31:0] o_pc;

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] dmem [DMEM_WORDS];

    // program table
    string       prog_name [NUM_PROGS];
    logic [31:0] prog_code [NUM_PROGS][PROG_WORDS];
    int          prog_len  [NUM_PROGS];
    int          exp_count [NUM_PROGS];
    logic [31:0] exp_addr  [NUM_PROGS][MAX_STORES];
    logic [31:0] exp_data  [NUM_PROGS][MAX_STORES];
    int          budget    [NUM_PROGS];

    logic [31:0] log_addr [$];  // byte addresses
    logic [31:0] log_data [$];

    int   error_count;
    logic table_ready;

    riscv_pipeline #(
        .NUM_REGS (32),
        .RESET_PC (32'h0)
    ) riscv_pipeline_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_imem_rdata (i_imem_rdata),
        .i_dmem_rdata (i_dmem_rdata),
        .o_imem_addr  (o_imem_addr),
        .o_dmem_ren   (o_dmem_ren),
        .o_dmem_wen   (o_dmem_wen),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_wdata (o_dmem_wdata),
        .o_pc         (o_pc)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // single cycle memories with combinational reads
    assign i_imem_rdata = (o_imem_addr < IMEM_WORDS) ? imem[o_imem_addr[3:0]] : NOP_WORD;
    assign i_dmem_rdata = (o_dmem_ren && o_dmem_addr < DMEM_WORDS) ?
                          dmem[o_dmem_addr[5:0]] : 32'h0;  // data only on a read

    always @(posedge clk) begin
        if (rst_n && o_dmem_wen) begin
            if (o_dmem_addr < DMEM_WORDS) begin
                dmem[o_dmem_addr[5:0]] <= o_dmem_wdata;
            end
            log_addr.push_back({o_dmem_addr, 2'b00});
            log_data.push_back(o_dmem_wdata);
        end
    end

    // instruction encoders
    function automatic logic [31:0] reg_op(input logic [2:0] f3, input logic alt,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {(alt ? 7'h20 : 7'h00), rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] imm_op(input logic [2:0] f3, input logic alt,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [31:0] imm);
        logic [11:0] field;
        field = alt ? {7'h20, imm[4:0]} : imm[11:0];  // srai carries bit 30
        return {field, rs1, f3, rd, 7'h13};
    endfunction

    function automatic logic [31:0] load_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [31:0] imm);
        return {imm[11:0], rs1, 3'b010, rd, 7'h03};
    endfunction

    function automatic logic [31:0] store_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                               input logic [31:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] branch_to(input logic [2:0] f3, input logic [4:0] rs1,
                                              input logic [4:0] rs2, input logic [31:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] jal_to(input logic [4:0] rd, input logic [31:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    function automatic logic [31:0] jalr_to(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [31:0] imm);
        return {imm[11:0], rs1, 3'b000, rd, 7'h67};
    endfunction

    task automatic emit(input int p, input logic [31:0] word);
        prog_code[p][prog_len[p]] = word;
        prog_len[p]++;
    endtask

    task automatic expect_store(input int p, input logic [31:0] addr, input logic [31:0] data);
        exp_addr[p][exp_count[p]] = addr;
        exp_data[p][exp_count[p]] = data;
        exp_count[p]++;
    endtask

    `include "tb_programs.svh"

    task automatic run_program(input int p);
        @(posedge clk);
        rst_n <= 1'b0;
        for (int a = 0; a < IMEM_WORDS; a++) begin
            imem[a] = (a < prog_len[p]) ? prog_code[p][a] : NOP_WORD;
        end
        for (int a = 0; a < DMEM_WORDS; a++) begin
            dmem[a] = $urandom();  // loads must never see a value the program did not store
        end
        log_addr.delete();
        log_data.delete();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);  // first cycle out of reset
        assert (o_pc === 32'h0) else begin
            $display("[ERROR] %s o_pc after reset: expected %h got %h", prog_name[p],
                     32'h0, o_pc);
            error_count++;
        end
        assert (o_dmem_wen === 1'b0) else begin
            $display("[ERROR] %s o_dmem_wen after reset: expected %h got %h", prog_name[p],
                     1'b0, o_dmem_wen);
            error_count++;
        end
        assert (o_dmem_ren === 1'b0) else begin
            $display("[ERROR] %s o_dmem_ren after reset: expected %h got %h", prog_name[p],
                     1'b0, o_dmem_ren);
            error_count++;
        end
        repeat (budget[p]) @(posedge clk);
        @(negedge clk);  // store log settled
    endtask

    // store log against the expected list in order
    task automatic check_stores(input int p);
        int n;
        n = log_addr.size();
        assert (n == exp_count[p]) else begin
            $display("%s made %0d stores where %0d were expected", prog_name[p], n,
                     exp_count[p]);
            error_count++;
        end
        for (int k = 0; k < exp_count[p] && k < n; k++) begin
            assert (log_addr[k] == exp_addr[p][k]) else begin
                $display("[ERROR] %s store %0d o_dmem_addr (byte): expected %h got %h",
                         prog_name[p], k, exp_addr[p][k], log_addr[k]);
                error_count++;
            end
            assert (log_data[k] == exp_data[p][k]) else begin
                $display("[ERROR] %s store %0d o_dmem_wdata: expected %h got %h",
                         prog_name[p], k, exp_data[p][k], log_data[k]);
                error_count++;
            end
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        error_count  = 0;
        table_ready  = 1'b0;
        void'($urandom(98));
        build_program_table();
        table_ready = 1'b1;
        for (int p = 0; p < NUM_PROGS; p++) begin
            run_program(p);
            check_stores(p);
        end
        $display("%0d errors over %0d programs", error_count, NUM_PROGS);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // watchdog sized from the table
    initial begin
        int limit;
        wait (table_ready);
        limit = WD_MARGIN;
        for (int p = 0; p < NUM_PROGS; p++) begin
            limit += budget[p] + RESET_CYCLES + 2;
        end
        repeat (limit) @(posedge clk);
        $display("timeout after %0d cycles, %0d errors so far", limit, error_count);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: all.f
+incdir+tests
source/rv_pkg.sv
source/fwd_if.sv
source/register_file.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/riscv_pipeline.sv
tests/tb_riscv_pipeline.sv
